/* rv_core.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/data_mem.sv
hdl/result_stage.sv
hdl/rv_core.sv
verification/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the rv_core testbench with Verilator, run it and search the log for the result
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log
grep -qx "Simulation PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

/* verification/rv_core_tb.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module rv_core_tb;

    localparam int N_RANDOM    = 300;
    localparam int N_INSTR     = 31 + 62 + 32 + N_RANDOM;
    localparam int CYCLE_LIMIT = 20 * N_INSTR + 16 + 50;
    // Bottom of data memory, fully written before the first load
    localparam int WIN_WORDS   = `DMEM_WORDS / 8;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic [31:0]            due;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    logic [`XLEN-1:0]       instr;
    logic                   retire_valid;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;
    logic                   illegal_instr;

    // Reference model
    logic [`XLEN-1:0]       regs [`REG_COUNT];
    logic [7:0]             mem_bytes [WIN_WORDS*4];
    expect_t                exp_q [$];

    logic                   head_valid = 1'b0;
    logic [`REG_ADDR_W-1:0] head_rd    = '0;
    logic [`XLEN-1:0]       head_data  = '0;
    logic [31:0]            head_due   = '0;
    logic [31:0]            cyc        = '0;
    logic                   ill_next   = 1'b0;
    logic                   ill_exp    = 1'b0;
    logic [4:0]             last_rd    = '0;
    logic [4:0]             prev_rd    = '0;
    logic [31:0]            lcg_state  = 32'd22392;
    int                     run_cycles = 0;

    rv_core rv_core_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .illegal_instr (illegal_instr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5;
            clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next()) % n;
    endfunction

    // RV32I arithmetic semantics, alt selects SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [6:0] addr);
        case (f3)
            3'b000: return {{24{mem_bytes[addr][7]}}, mem_bytes[addr]};
            3'b001: return {{16{mem_bytes[addr + 7'd1][7]}}, mem_bytes[addr + 7'd1],
                            mem_bytes[addr]};
            3'b100: return {24'b0, mem_bytes[addr]};
            3'b101: return {16'b0, mem_bytes[addr + 7'd1], mem_bytes[addr]};
            default: return {mem_bytes[addr + 7'd3], mem_bytes[addr + 7'd2],
                             mem_bytes[addr + 7'd1], mem_bytes[addr]};
        endcase
    endfunction

    function automatic void store_ref(input logic [2:0] f3, input logic [6:0] addr,
                                      input logic [31:0] data);
        mem_bytes[addr] = data[7:0];
        if (f3 != 3'd0) begin
            mem_bytes[addr + 7'd1] = data[15:8];
        end
        if (f3 == 3'd2) begin
            mem_bytes[addr + 7'd2] = data[23:16];
            mem_bytes[addr + 7'd3] = data[31:24];
        end
    endfunction

    // Aligned to the access size
    function automatic logic [6:0] pick_addr(input logic [1:0] size);
        logic [6:0] base;
        base = 7'(rand_below(WIN_WORDS) * 4);
        case (size)
            2'd0: return base + 7'(rand_below(4));
            2'd1: return base + 7'(rand_below(2) * 2);
            default: return base;
        endcase
    endfunction

    // Biased toward the last two destinations to hit forwarding
    function automatic logic [4:0] pick_src();
        case (rand_below(4))
            0: return last_rd;
            1: return prev_rd;
            default: return 5'(rand_below(32));
        endcase
    endfunction

    function automatic void refresh_head();
        head_valid = exp_q.size() > 0;
        if (head_valid) begin
            head_rd   = exp_q[0].rd;
            head_data = exp_q[0].data;
            head_due  = exp_q[0].due;
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (head_valid && head_due == cyc) begin
            void'(exp_q.pop_front());
        end
        cyc      = cyc + 32'd1;
        ill_exp  = ill_next;
        ill_next = 1'b0;
        refresh_head();
    endtask

    // rd of zero means nothing retires
    task automatic issue(input logic [31:0] word, input logic [4:0] rd,
                         input logic [31:0] value, input logic illegal);
        instr_valid = 1'b1;
        instr       = word;
        if (rd != 5'd0) begin
            regs[rd] = value;
            exp_q.push_back('{rd, value, cyc + 32'd2});
            prev_rd = last_rd;
            last_rd = rd;
        end
        ill_next = illegal;
        refresh_head();
        next_cycle();
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            instr_valid = 1'b0;
            instr       = rand_word();
            next_cycle();
        end
    endtask

    task automatic random_instr();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] imm20;
        logic [6:0]  opc;
        logic [6:0]  addr;
        kind = rand_below(16);
        rd   = 5'(rand_below(31) + 1);
        rs1  = pick_src();
        rs2  = pick_src();
        f3   = 3'(rand_below(8));
        alt  = (f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1;
        if (kind == 15) begin
            // Result to x0 must not retire
            kind = 0;
            rd   = 5'd0;
        end
        if (kind < 5) begin
            issue({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33}, rd,
                  alu_ref(f3, alt, regs[rs1], regs[rs2]), 1'b0);
        end else if (kind < 9) begin
            imm = 12'(rand_below(4096));
            if (f3 != 3'd5) begin
                alt = 1'b0;
            end
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end
            issue({imm, rs1, f3, rd, 7'h13}, rd,
                  alu_ref(f3, alt, regs[rs1], {{20{imm[11]}}, imm}), 1'b0);
        end else if (kind == 9) begin
            imm20 = 20'(rand_word());
            issue({imm20, rd, 7'h37}, rd, {imm20, 12'b0}, 1'b0);
        end else if (kind < 12) begin
            f3 = 3'(rand_below(5));
            if (f3 == 3'd3) begin
                f3 = 3'd5;
            end
            addr = pick_addr(f3[1:0]);
            issue({5'b0, addr, 5'd0, f3, rd, 7'h03}, rd, load_ref(f3, addr), 1'b0);
        end else if (kind < 14) begin
            f3   = 3'(rand_below(3));
            addr = pick_addr(f3[1:0]);
            imm  = {5'b0, addr};
            store_ref(f3, addr, regs[rs2]);
            issue({imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23}, 5'd0, 32'd0, 1'b0);
        end else begin
            do begin
                opc = 7'(rand_below(128));
            end while (opc inside {7'h33, 7'h13, 7'h37, 7'h03, 7'h23});
            issue({25'(rand_word()), opc}, 5'd0, 32'd0, 1'b1);
        end
    endtask

    a_retire_expected: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> head_valid && cyc == head_due)
        else stop_with_failure($sformatf("CHECK FAILED at %0t: unexpected retire of x%0d",
            $time, retire_rd));

    a_retire_on_time: assert property (@(negedge clk) disable iff (rst)
        (head_valid && cyc == head_due) |-> retire_valid)
        else stop_with_failure($sformatf("CHECK FAILED at %0t: missing retire of x%0d",
            $time, head_rd));

    a_retire_rd: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> retire_rd == head_rd)
        else stop_with_failure($sformatf("CHECK FAILED at %0t: retire_rd %0d, expected %0d",
            $time, retire_rd, head_rd));

    a_retire_data: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> retire_data == head_data)
        else stop_with_failure($sformatf("CHECK FAILED at %0t: x%0d got %h, expected %h",
            $time, retire_rd, retire_data, head_data));

    a_illegal_pulse: assert property (@(negedge clk) disable iff (rst)
        illegal_instr == ill_exp)
        else stop_with_failure($sformatf("CHECK FAILED at %0t: illegal_instr %b, expected %b",
            $time, illegal_instr, ill_exp));

    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles > CYCLE_LIMIT) begin
            stop_with_failure($sformatf("Timeout after %0d cycles, the test did not finish",
                run_cycles));
        end
    end

    initial begin
        logic [19:0] imm20;
        logic [11:0] imm;
        logic [4:0]  rs2;
        int          gap;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Every register reads zero after reset
        for (int r = 1; r < 32; r++) begin
            issue({7'h00, 5'd0, 5'(r), 3'd0, 5'(r), 7'h33}, 5'(r),
                  alu_ref(3'd0, 1'b0, regs[5'(r)], regs[0]), 1'b0);
        end

        // LUI then a dependent ADDI in the next slot
        for (int r = 1; r < 32; r++) begin
            imm20 = 20'(rand_word());
            issue({imm20, 5'(r), 7'h37}, 5'(r), {imm20, 12'b0}, 1'b0);
            imm = 12'(rand_below(4096));
            issue({imm, 5'(r), 3'd0, 5'(r), 7'h13}, 5'(r),
                  alu_ref(3'd0, 1'b0, regs[5'(r)], {{20{imm[11]}}, imm}), 1'b0);
        end

        // Fill the data window with SW
        for (int w = 0; w < WIN_WORDS; w++) begin
            rs2 = 5'(rand_below(31) + 1);
            imm = 12'(w * 4);
            store_ref(3'd2, 7'(w * 4), regs[rs2]);
            issue({imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23}, 5'd0, 32'd0, 1'b0);
        end

        repeat (N_RANDOM) begin
            random_instr();
            gap = 0;
            if (rand_below(8) >= 5) begin
                gap = rand_below(3) + 1;
            end
            idle_cycles(gap);
        end

        while (head_valid) begin
            idle_cycles(1);
        end
        idle_cycles(4);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module rv_core
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [`XLEN-1:0]       instr,
    output logic                   retire_valid,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic [`XLEN-1:0]       retire_data,
    output logic                   illegal_instr
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    ex_rec_t                ex_rec;
    res_rec_t               res_rec;
    logic                   mem_en;
    logic [`XLEN/8-1:0]     mem_we;
    logic [`XLEN-1:0]       mem_addr;
    logic [`XLEN-1:0]       mem_wdata;
    logic [`XLEN-1:0]       mem_rdata;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    decode_stage decode_stage_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .ex_rec        (ex_rec),
        .illegal_instr (illegal_instr)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .rst       (rst),
        .ex_rec    (ex_rec),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .res_rec   (res_rec)
    );

    data_mem data_mem_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    result_stage result_stage_i (
        .res_rec   (res_rec),
        .mem_rdata (mem_rdata),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    // Every writeback is a retirement
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

/* hdl/result_stage.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module result_stage
    import pipe_pkg::*;
(
    input  res_rec_t               res_rec,
    input  logic [`XLEN-1:0]       mem_rdata,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    logic [7:0]       sel_byte;
    logic [15:0]      sel_half;
    logic [`XLEN-1:0] load_val;

    // Halfwords are aligned, so only bit 1 of the offset matters
    assign sel_byte = mem_rdata[{res_rec.byte_off, 3'b000} +: 8];
    assign sel_half = res_rec.byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (res_rec.load_size)
            BYTE:    load_val = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
            HALF:    load_val = {{(`XLEN-16){sel_half[15]}}, sel_half};
            BYTE_U:  load_val = {{(`XLEN-8){1'b0}}, sel_byte};
            HALF_U:  load_val = {{(`XLEN-16){1'b0}}, sel_half};
            default: load_val = mem_rdata;
        endcase
    end

    assign wb_en   = res_rec.valid && res_rec.writes_rd && res_rec.rd != '0;
    assign wb_rd   = res_rec.rd;
    assign wb_data = res_rec.is_load ? load_val : res_rec.alu_value;

    // Halfword and word selects above assume aligned loads
    always_comb begin
        if (res_rec.valid && res_rec.is_load) begin
            a_load_aligned: assert (
                (res_rec.load_size != WORD || res_rec.byte_off == 2'b00)
                && ((res_rec.load_size != HALF && res_rec.load_size != HALF_U)
                    || !res_rec.byte_off[0]))
                else $error("misaligned load in result stage");
        end
    end

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module data_mem (
    input  logic                 clk,
    input  logic                 mem_en,
    input  logic [`XLEN/8-1:0]   mem_we,
    input  logic [`XLEN-1:0]     mem_addr,
    input  logic [`XLEN-1:0]     mem_wdata,
    output logic [`XLEN-1:0]     mem_rdata
);

    logic [`XLEN-1:0]   mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] word_idx;

    // Byte offset and upper bits are dropped
    assign word_idx = mem_addr[`DMEM_ADDR_LSB +: `DMEM_AW];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            for (int b = 0; b < `XLEN/8; b++) begin
                if (mem_we[b]) begin
                    mem[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
            // Read returns the word as it was before this write
            mem_rdata <= mem[word_idx];
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module execute_stage
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  ex_rec_t                ex_rec,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   mem_en,
    output logic [`XLEN/8-1:0]     mem_we,
    output logic [`XLEN-1:0]       mem_addr,
    output logic [`XLEN-1:0]       mem_wdata,
    output res_rec_t               res_rec
);

    logic [`XLEN-1:0]   src_a;
    logic [`XLEN-1:0]   src_b;
    logic [`XLEN-1:0]   alu_b;
    logic [`XLEN-1:0]   alu_y;
    logic [4:0]         shamt;
    logic [1:0]         byte_off;
    logic [`XLEN/8-1:0] byte_mask;
    res_rec_t           nxt;

    // Result stage holds the instruction one slot ahead
    assign src_a = (wb_en && ex_rec.rs1 != '0 && wb_rd == ex_rec.rs1) ? wb_data : ex_rec.op_a;
    assign src_b = (wb_en && ex_rec.rs2 != '0 && wb_rd == ex_rec.rs2) ? wb_data : ex_rec.op_b;

    assign alu_b = ex_rec.use_imm ? ex_rec.imm : src_b;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (ex_rec.alu_op)
            ALU_ADD:    alu_y = src_a + alu_b;
            ALU_SUB:    alu_y = src_a - alu_b;
            ALU_SLL:    alu_y = src_a << shamt;
            ALU_SLT:    alu_y = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
            ALU_SLTU:   alu_y = {{(`XLEN-1){1'b0}}, src_a < alu_b};
            ALU_XOR:    alu_y = src_a ^ alu_b;
            ALU_SRL:    alu_y = src_a >> shamt;
            ALU_SRA:    alu_y = $signed(src_a) >>> shamt;
            ALU_OR:     alu_y = src_a | alu_b;
            ALU_AND:    alu_y = src_a & alu_b;
            ALU_PASS_B: alu_y = alu_b;
            default:    alu_y = '0;
        endcase
    end

    // Loads and stores decode to ADD with the immediate, so alu_y is rs1 + imm
    assign mem_addr = alu_y;
    assign byte_off = alu_y[1:0];

    always_comb begin
        case (ex_rec.load_size)
            BYTE:    byte_mask = 4'b0001 << byte_off;
            HALF:    byte_mask = 4'b0011 << byte_off;
            default: byte_mask = 4'b1111;
        endcase
    end

    assign mem_en    = ex_rec.valid && (ex_rec.is_load || ex_rec.is_store);
    assign mem_we    = (ex_rec.valid && ex_rec.is_store) ? byte_mask : '0;
    assign mem_wdata = src_b << {byte_off, 3'b000};

    always_comb begin
        nxt           = '0;
        nxt.valid     = ex_rec.valid;
        nxt.rd        = ex_rec.rd;
        nxt.writes_rd = ex_rec.writes_rd;
        nxt.is_load   = ex_rec.is_load;
        nxt.load_size = ex_rec.load_size;
        nxt.byte_off  = byte_off;
        nxt.alu_value = alu_y;
    end

    always_ff @(posedge clk) begin
        res_rec <= nxt;
        if (rst) begin
            res_rec.valid <= 1'b0;
        end
    end

    // Shifted byte enables only stay inside the word for aligned stores
    a_store_aligned: assert property (@(posedge clk) disable iff (rst)
        (mem_we != '0) |-> ((ex_rec.load_size == WORD && byte_off == 2'b00)
            || (ex_rec.load_size == HALF && !byte_off[0])
            || ex_rec.load_size == BYTE))
        else $error("misaligned data memory store");

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [`XLEN-1:0]       instr,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output ex_rec_t                ex_rec,
    output logic                   illegal_instr
);

    instr_u           iw;
    ex_rec_t          nxt;
    logic             legal;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;

    // alt selects SUB or SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign iw       = instr;
    assign rs1_addr = iw.r_fmt.rs1;
    assign rs2_addr = iw.r_fmt.rs2;

    assign imm_i = {{(`XLEN-12){iw.i_fmt.imm12[11]}}, iw.i_fmt.imm12};
    assign imm_s = {{(`XLEN-12){iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
    assign imm_u = {iw.u_fmt.imm20, 12'b0};

    always_comb begin
        nxt       = '0;
        legal     = 1'b1;
        nxt.rd    = iw.r_fmt.rd;
        nxt.rs1   = iw.r_fmt.rs1;
        nxt.rs2   = iw.r_fmt.rs2;
        nxt.op_a  = rs1_data;
        nxt.op_b  = rs2_data;
        case (iw.r_fmt.opcode)
            OPC_OP: begin
                nxt.writes_rd = 1'b1;
                nxt.alu_op    = arith_op(iw.r_fmt.funct3, iw.r_fmt.funct7[5]);
            end
            OPC_OP_IMM: begin
                nxt.writes_rd = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_i;
                // Only shifts borrow imm bit 10 as the arithmetic flag
                nxt.alu_op    = arith_op(iw.i_fmt.funct3,
                    iw.i_fmt.funct3 == F3_SRL_SRA && iw.r_fmt.funct7[5]);
            end
            OPC_LUI: begin
                nxt.writes_rd = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_u;
                nxt.alu_op    = ALU_PASS_B;
            end
            OPC_LOAD: begin
                nxt.writes_rd = 1'b1;
                nxt.is_load   = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_i;
                nxt.alu_op    = ALU_ADD;
                case (iw.i_fmt.funct3)
                    MEM_B:   nxt.load_size = BYTE;
                    MEM_H:   nxt.load_size = HALF;
                    MEM_W:   nxt.load_size = WORD;
                    MEM_BU:  nxt.load_size = BYTE_U;
                    MEM_HU:  nxt.load_size = HALF_U;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                nxt.is_store = 1'b1;
                nxt.use_imm  = 1'b1;
                nxt.imm      = imm_s;
                nxt.alu_op   = ALU_ADD;
                case (iw.s_fmt.funct3)
                    MEM_B:   nxt.load_size = BYTE;
                    MEM_H:   nxt.load_size = HALF;
                    MEM_W:   nxt.load_size = WORD;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        nxt.valid = instr_valid && legal;
    end

    always_ff @(posedge clk) begin
        ex_rec        <= nxt;
        illegal_instr <= instr_valid && !legal;
        if (rst) begin
            ex_rec.valid  <= 1'b0;
            illegal_instr <= 1'b0;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 reads as zero; a same-cycle write is seen by the reader
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // Result stage must never target x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_addr != '0)
        else $error("register file write to x0");

endmodule

/* hdl/pipe_pkg.sv */
`include "core_macros.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Also gives the access size of stores
    typedef enum logic [2:0] {
        BYTE,
        HALF,
        WORD,
        BYTE_U,
        HALF_U
    } load_size_e;

    // Decode to execute
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       op_a;
        logic [`XLEN-1:0]       op_b;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        alu_op_e                alu_op;
        logic                   is_load;
        logic                   is_store;
        load_size_e             load_size;
        logic                   writes_rd;
    } ex_rec_t;

    // Execute to result
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   writes_rd;
        logic                   is_load;
        load_size_e             load_size;
        logic [1:0]             byte_off;
        logic [`XLEN-1:0]       alu_value;
    } res_rec_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

    // Register-register format, also used for the rs1/rs2/rd fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_funct3_e;

endpackage

/* hdl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path width
`define XLEN 32

// Integer register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Data memory geometry in words
`define DMEM_WORDS 256
`define DMEM_AW 8

// Byte address bit where the word index starts
`define DMEM_ADDR_LSB 2

`endif
